// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - verilog/isaPkg.sv
  - verilog/corePkg.sv
  - verilog/hazardIf.sv
  - verilog/fetchUnit.sv
  - verilog/decodeStage.sv
  - verilog/registerFile.sv
  - verilog/executeStage.sv
  - verilog/memoryStage.sv
  - verilog/hazardUnit.sv
  - verilog/mipsCore.sv
  - target: test
    files:
      - bench/pipeline_checker.sv
      - bench/coreTb.sv

// ==== bench/coreTb.sv ====
`timescale 1ns/1ns
module coreTb;
    import corePkg::*;
    import isaPkg::*;

    localparam int prologLen     = 31;   // ORI seeds r1..r31
    localparam int bodyLen       = 200;
    localparam int padLen        = 5;    // Room for the farthest forward branch
    localparam int dumpLen       = 32;
    localparam int progLen       = prologLen + bodyLen + padLen + dumpLen;
    localparam int imemWords     = 512;
    localparam int dmemWords     = 128;
    localparam int dumpBase      = 256;  // Byte address above the 64 random words
    localparam int maxAckDelay   = 3;
    localparam int timeoutCycles = 20 * progLen * maxAckDelay;
    localparam int resetCycles   = 16;
    localparam int drainCycles   = 40;
    localparam logic [31:0] lfsrTaps = 32'h8020_0003;

    logic     clock;
    logic     rst;
    instrT    instRdata;
    logic     instAck, instRead;
    wordAddrT instAddr;
    wordT     dataRdata, dataWdata;
    logic     dataAck, dataRead, dataWrite;
    wordAddrT dataAddr;

    logic [31:0] lfsrState = 32'h927c2027;
    instrT       imem [imemWords];
    wordT        dmem [dmemWords];
    wordAddrT    fetchQ [$];       // Expected fetch order from the reference
    wordAddrT    loadQ [$];
    wordAddrT    storeAddrQ [$];
    wordT        storeDataQ [$];
    int          instWait = 0;
    int          dataWait = 0;

    mipsCore dut_i (
        .clock, .rst, .instRdata, .instAck, .instRead, .instAddr,
        .dataRdata, .dataAck, .dataRead, .dataWrite, .dataAddr, .dataWdata
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ lfsrTaps : lfsrState >> 1;
        end
        return v;
    endfunction

    function automatic regIdxT pickReg();
        return regIdxT'(1 + randBits(3) % 7);  // Only r1..r7, so hazards are frequent
    endfunction

    function automatic instrT rType(functT fn, regIdxT rs, regIdxT rt, regIdxT rd);
        return {opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic instrT iType(opcodeT op, regIdxT rs, regIdxT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT fillWord(int idx);
        return (idx * 32'h9e37_79b9) ^ 32'ha5a5_0000;
    endfunction

    task automatic abortRun(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic buildProgram();
        int pc;
        int k;
        logic [3:0] kind;
        regIdxT rs, rt, rd;
        for (k = 0; k < imemWords; k++)
            imem[k] = nopInstr;
        for (k = 1; k < 32; k++)
            imem[k - 1] = iType(opOri, regZero, regIdxT'(k), 16'(randBits(16)));
        pc = prologLen;
        repeat (bodyLen) begin
            kind = 4'(randBits(4));
            rs = pickReg();
            rt = pickReg();
            rd = pickReg();
            case (kind)
                0, 1:   imem[pc] = rType(fnAddu, rs, rt, rd);
                2:      imem[pc] = rType(fnSubu, rs, rt, rd);
                3:      imem[pc] = rType(fnAnd, rs, rt, rd);
                4:      imem[pc] = rType(fnOr, rs, rt, rd);
                5:      imem[pc] = rType(fnSlt, rs, rt, rd);
                6, 7:   imem[pc] = iType(opAddiu, rs, rt, 16'(randBits(16)));
                8:      imem[pc] = iType(opOri, rs, rt, 16'(randBits(16)));
                9:      imem[pc] = iType(opLui, regZero, rt, 16'(randBits(16)));
                10, 11: imem[pc] = iType(opLw, regZero, rt, {8'd0, 6'(randBits(6)), 2'b00});
                12, 13: imem[pc] = iType(opSw, regZero, rt, {8'd0, 6'(randBits(6)), 2'b00});
                14:     imem[pc] = iType(opBeq, rs, rt, 16'(1 + randBits(2)));
                default: imem[pc] = iType(opBne, rs, rt, 16'(1 + randBits(2)));
            endcase
            pc++;
        end
        pc += padLen;
        for (k = 0; k < dumpLen; k++)  // Register dump, r0 included
            imem[pc + k] = iType(opSw, regZero, regIdxT'(k), 16'(dumpBase + 4 * k));
    endtask

    // Instruction set model with pc/npc delay-slot semantics
    task automatic runReference();
        wordT   regs [32];
        wordT   refMem [dmemWords];
        wordT   pc, npc, nextNpc, a, b, simm, addr, res;
        instrT  ins;
        logic   wr;
        regIdxT dst;
        int     k;
        for (k = 0; k < 32; k++)
            regs[k] = '0;
        for (k = 0; k < dmemWords; k++)
            refMem[k] = fillWord(k);
        pc  = resetPc;
        npc = resetPc + 32'd4;
        while (pc[31:2] < progLen) begin
            ins = imem[pc[31:2]];
            fetchQ.push_back(pc[31:2]);
            a       = regs[ins[25:21]];
            b       = regs[ins[20:16]];
            simm    = {{16{ins[15]}}, ins[15:0]};
            nextNpc = npc + 32'd4;
            dst     = ins[20:16];
            wr      = 1'b1;
            res     = '0;
            case (ins[31:26])
                opSpecial: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        fnAddu:  res = a + b;
                        fnSubu:  res = a - b;
                        fnAnd:   res = a & b;
                        fnOr:    res = a | b;
                        fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                opAddiu: res = a + simm;
                opOri:   res = a | {16'h0, ins[15:0]};
                opLui:   res = {ins[15:0], 16'h0};
                opLw: begin
                    addr = a + simm;
                    loadQ.push_back(addr[31:2]);
                    res = refMem[addr[8:2]];
                end
                opSw: begin
                    addr = a + simm;
                    wr = 1'b0;
                    storeAddrQ.push_back(addr[31:2]);
                    storeDataQ.push_back(b);
                    refMem[addr[8:2]] = b;
                end
                opBeq: begin
                    wr = 1'b0;
                    if (a == b)
                        nextNpc = pc + 32'd4 + (simm << 2);
                end
                opBne: begin
                    wr = 1'b0;
                    if (a != b)
                        nextNpc = pc + 32'd4 + (simm << 2);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != regZero)
                regs[dst] = res;
            pc  = npc;
            npc = nextNpc;
        end
    endtask

    task automatic checkStore();
        assert (storeAddrQ.size() != 0) else
            abortRun($sformatf("[ERROR] %0t: extra store to word %0d data %h",
                               $time, dataAddr, dataWdata));
        assert (dataAddr == storeAddrQ[0] && dataWdata == storeDataQ[0]) else
            abortRun($sformatf("[ERROR] %0t: store word %0d data %h, expected word %0d data %h",
                               $time, dataAddr, dataWdata, storeAddrQ[0], storeDataQ[0]));
        void'(storeAddrQ.pop_front());
        void'(storeDataQ.pop_front());
        dmem[dataAddr[6:0]] = dataWdata;
    endtask

    task automatic checkLoad();
        assert (loadQ.size() != 0) else
            abortRun($sformatf("[ERROR] %0t: extra load from word %0d", $time, dataAddr));
        assert (dataAddr == loadQ[0]) else
            abortRun($sformatf("[ERROR] %0t: load from word %0d, expected word %0d",
                               $time, dataAddr, loadQ[0]));
        void'(loadQ.pop_front());
        dataRdata = dmem[dataAddr[6:0]];
    endtask

    // Both memory models, with acks after 0 to 3 cycles
    always @(negedge clock) begin
        instAck = 1'b0;
        dataAck = 1'b0;
        if (!rst && instRead) begin
            if (instWait == 0) begin
                if (fetchQ.size() != 0) begin
                    assert (instAddr == fetchQ[0]) else
                        abortRun($sformatf("[ERROR] %0t: fetch from word %0d, expected word %0d",
                                           $time, instAddr, fetchQ[0]));
                    void'(fetchQ.pop_front());
                end
                instRdata = (instAddr < imemWords) ? imem[instAddr] : nopInstr;
                instAck   = 1'b1;
                instWait  = randBits(2);
            end else begin
                instWait--;
            end
        end
        if (!rst && (dataRead || dataWrite)) begin
            if (dataWait == 0) begin
                if (dataWrite)
                    checkStore();
                else
                    checkLoad();
                dataAck  = 1'b1;
                dataWait = randBits(2);
            end else begin
                dataWait--;
            end
        end
    end

    initial begin
        repeat (timeoutCycles) @(posedge clock);
        abortRun("Timeout: the core did not finish its store sequence in time");
    end

    initial begin
        int k;
        rst       = 1'b1;
        instRdata = '0;
        instAck   = 1'b0;
        dataRdata = '0;
        dataAck   = 1'b0;
        for (k = 0; k < dmemWords; k++)
            dmem[k] = fillWord(k);
        buildProgram();
        runReference();
        repeat (resetCycles) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        while (storeAddrQ.size() != 0)
            @(negedge clock);
        repeat (drainCycles) @(negedge clock);  // Room for a stray store to show up
        assert (loadQ.size() == 0 && fetchQ.size() == 0) else
            abortRun($sformatf("[ERROR] %0t: %0d loads and %0d fetches never seen",
                               $time, loadQ.size(), fetchQ.size()));
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== bench/pipeline_checker.sv ====
`timescale 1ns/1ns
module pipeline_checker (
    input logic              clock,
    input logic              rst,
    input logic              instRead,
    input logic              instAck,
    input corePkg::wordAddrT instAddr,
    input logic              dataRead,
    input logic              dataWrite,
    input logic              dataAck,
    input corePkg::wordAddrT dataAddr,
    input corePkg::wordT     dataWdata
);

    oneRequest: assert property (@(posedge clock) disable iff (rst) !(dataRead && dataWrite))
        else $error("dataRead and dataWrite high together");

    // Requests hold with a stable address until acked
    readHeld: assert property (@(posedge clock) disable iff (rst)
        dataRead && !dataAck |=> dataRead && $stable(dataAddr))
        else $error("data read dropped or moved before its ack");

    writeHeld: assert property (@(posedge clock) disable iff (rst)
        dataWrite && !dataAck |=> dataWrite && $stable(dataAddr) && $stable(dataWdata))
        else $error("data write dropped or moved before its ack");

    fetchHeld: assert property (@(posedge clock) disable iff (rst)
        instRead && !instAck |=> instRead && $stable(instAddr))
        else $error("instruction read dropped or moved before its ack");

    quietInReset: assert property (@(posedge clock) rst ##1 rst |-> !instRead)  // From 2nd edge
        else $error("instRead high during reset");

endmodule

bind mipsCore pipeline_checker checker_i (
    .clock, .rst, .instRead, .instAck, .instAddr,
    .dataRead, .dataWrite, .dataAck, .dataAddr, .dataWdata
);

// ==== sources.f ====
verilog/isaPkg.sv
verilog/corePkg.sv
verilog/hazardIf.sv
verilog/fetchUnit.sv
verilog/decodeStage.sv
verilog/registerFile.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/hazardUnit.sv
verilog/mipsCore.sv
bench/pipeline_checker.sv
bench/coreTb.sv

// ==== verilog/corePkg.sv ====
package corePkg;

    typedef logic [31:0] wordT;
    typedef logic [29:0] wordAddrT;  // Byte address without the low two bits

    localparam wordT resetPc = 32'h0000_0000;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui
    } aluOpT;

    typedef enum logic [1:0] {
        fwdNone, fwdMem, fwdWb
    } fwdSelT;

    typedef enum logic {
        memIdle, memWait
    } memStateT;

    // Operand select shared by decode and execute
    function automatic wordT fwdMux(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

endpackage

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ns
module decodeStage (
    input  logic           clock,
    input  logic           rst,
    input  isaPkg::instrT  idInstr,
    input  corePkg::wordT  idPcPlus4,
    input  corePkg::wordT  rfRs,
    input  corePkg::wordT  rfRt,
    input  corePkg::wordT  memResult,
    input  corePkg::wordT  wbData,
    output isaPkg::regIdxT rsIdx,
    output isaPkg::regIdxT rtIdx,
    output logic           branchTaken,
    output corePkg::wordT  branchTarget,
    output corePkg::aluOpT exAluOp,
    output corePkg::wordT  exA,
    output corePkg::wordT  exB,
    output corePkg::wordT  exStoreData,
    output logic           exUseImm,
    output corePkg::wordT  exImm,
    output logic           exMemRead,
    output logic           exMemWrite,
    output logic           exRegWrite,
    output isaPkg::regIdxT exDest,
    output isaPkg::regIdxT exRs,
    output isaPkg::regIdxT exRt,
    hazardIf.decode        hazard
);
    import corePkg::*;
    import isaPkg::*;

    opcodeT op;
    functT  fn;
    regIdxT rd;
    aluOpT  aluOp;
    logic   useImm, zeroExt, memRead, memWrite, regWrite, rtDest;
    logic   isBranch, isBne, usesRt;
    wordT   imm, rsVal, rtVal;

    assign op    = idInstr[opLsb +: 6];
    assign fn    = idInstr[5:0];
    assign rsIdx = idInstr[rsLsb +: 5];
    assign rtIdx = idInstr[rtLsb +: 5];
    assign rd    = idInstr[rdLsb +: 5];

    always_comb begin
        aluOp = aluAdd;  // Anything unrecognized stays a no-op
        {useImm, zeroExt, memRead, memWrite, regWrite, rtDest} = '0;
        {isBranch, isBne, usesRt} = '0;
        case (op)
            opSpecial: begin
                usesRt = 1'b1;
                regWrite = fn inside {fnAddu, fnSubu, fnAnd, fnOr, fnSlt};
                case (fn)
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    default: aluOp = aluAdd;
                endcase
            end
            opAddiu: {useImm, regWrite, rtDest} = 3'b111;
            opOri: begin
                aluOp = aluOr;
                {useImm, zeroExt, regWrite, rtDest} = 4'b1111;
            end
            opLui: begin
                aluOp = aluLui;
                {useImm, regWrite, rtDest} = 3'b111;
            end
            opLw:    {useImm, memRead, regWrite, rtDest} = 4'b1111;
            opSw:    {useImm, memWrite, usesRt} = 3'b111;
            opBeq:   {isBranch, usesRt} = 2'b11;
            opBne:   {isBranch, isBne, usesRt} = 3'b111;
            default: ;
        endcase
    end

    assign imm   = zeroExt ? {16'h0, idInstr[15:0]} : {{16{idInstr[15]}}, idInstr[15:0]};
    assign rsVal = fwdMux(hazard.idRsFwd, rfRs, memResult, wbData);
    assign rtVal = fwdMux(hazard.idRtFwd, rfRt, memResult, wbData);

    assign branchTaken  = isBranch & ((rsVal == rtVal) ^ isBne);
    assign branchTarget = idPcPlus4 + {imm[29:0], 2'b00};

    assign hazard.idRs     = rsIdx;
    assign hazard.idRt     = rtIdx;
    assign hazard.idUsesRt = usesRt;
    assign hazard.idBranch = isBranch;

    always_ff @(posedge clock) begin
        if (rst) begin
            {exMemRead, exMemWrite, exRegWrite} <= '0;
        end else if (!hazard.stallAll) begin
            if (hazard.stallDecode) begin
                {exMemRead, exMemWrite, exRegWrite} <= '0;  // Bubble
            end else begin
                {exMemRead, exMemWrite, exRegWrite} <= {memRead, memWrite, regWrite};
                exAluOp     <= aluOp;
                exA         <= rsVal;
                exB         <= rtVal;
                exStoreData <= rtVal;
                exUseImm    <= useImm;
                exImm       <= imm;
                exDest      <= rtDest ? rtIdx : rd;
                exRs        <= rsIdx;
                exRt        <= rtIdx;
            end
        end
    end

endmodule

// ==== verilog/executeStage.sv ====
`timescale 1ns/1ns
module executeStage (
    input  logic           clock,
    input  logic           rst,
    input  corePkg::aluOpT exAluOp,
    input  corePkg::wordT  exA,
    input  corePkg::wordT  exB,
    input  corePkg::wordT  exStoreData,
    input  logic           exUseImm,
    input  corePkg::wordT  exImm,
    input  logic           exMemRead,
    input  logic           exMemWrite,
    input  logic           exRegWrite,
    input  isaPkg::regIdxT exDest,
    input  isaPkg::regIdxT exRs,
    input  isaPkg::regIdxT exRt,
    input  corePkg::wordT  memResult,
    input  corePkg::wordT  wbData,
    output corePkg::wordT  memAluResult,
    output corePkg::wordT  memStoreData,
    output logic           memRead,
    output logic           memWrite,
    output logic           memRegWrite,
    output isaPkg::regIdxT memDest,
    hazardIf.execute       hazard
);
    import corePkg::*;

    wordT opA, opB, storeVal, result;

    assign opA      = fwdMux(hazard.exRsFwd, exA, memResult, wbData);
    assign storeVal = fwdMux(hazard.exRtFwd, exStoreData, memResult, wbData);
    assign opB      = exUseImm ? exImm : fwdMux(hazard.exRtFwd, exB, memResult, wbData);

    always_comb begin
        case (exAluOp)
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluSlt:  result = {31'b0, $signed(opA) < $signed(opB)};
            aluLui:  result = {opB[15:0], 16'h0};
            default: result = opA + opB;
        endcase
    end

    assign hazard.exRs       = exRs;
    assign hazard.exRt       = exRt;
    assign hazard.exDest     = exDest;
    assign hazard.exRegWrite = exRegWrite;
    assign hazard.exMemRead  = exMemRead;

    always_ff @(posedge clock) begin
        if (rst) begin
            {memRead, memWrite, memRegWrite} <= '0;
        end else if (!hazard.stallAll) begin
            {memRead, memWrite, memRegWrite} <= {exMemRead, exMemWrite, exRegWrite};
            memAluResult <= result;
            memStoreData <= storeVal;
            memDest      <= exDest;
        end
    end

endmodule

// ==== verilog/fetchUnit.sv ====
`timescale 1ns/1ns
module fetchUnit (
    input  logic              clock,
    input  logic              rst,
    input  isaPkg::instrT     instRdata,
    input  logic              instAck,
    input  logic              branchTaken,
    input  corePkg::wordT     branchTarget,
    output logic              instRead,
    output corePkg::wordAddrT instAddr,
    output isaPkg::instrT     idInstr,
    output corePkg::wordT     idPcPlus4,
    hazardIf.fetch            hazard
);
    import corePkg::*;
    import isaPkg::*;

    wordT  pc;
    wordT  pcPlus4;
    logic  running;    // Low until the first cycle after reset
    logic  fetched;    // Masks the port once an acked word waits out a stall
    instrT heldInstr;
    logic  gotNow;

    assign instRead = running & ~fetched;
    assign instAddr = pc[31:2];
    assign gotNow   = instRead & instAck;
    assign pcPlus4  = pc + 32'd4;

    assign hazard.fetchBusy = instRead & ~instAck;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc      <= resetPc;
            running <= 1'b0;
            fetched <= 1'b0;
            idInstr <= nopInstr;
        end else begin
            running <= 1'b1;
            if (!hazard.stallFetch) begin
                if (fetched || gotNow) begin
                    idInstr   <= fetched ? heldInstr : instRdata;
                    idPcPlus4 <= pcPlus4;
                    // Branch in decode leaves together with its delay slot arriving
                    pc        <= branchTaken ? branchTarget : pcPlus4;
                end else begin
                    idInstr <= nopInstr;
                end
                fetched <= 1'b0;
            end else if (gotNow) begin
                fetched <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (gotNow)
            heldInstr <= instRdata;
    end

endmodule

// ==== verilog/hazardIf.sv ====
`timescale 1ns/1ns
interface hazardIf;
    import corePkg::*;
    import isaPkg::*;

    regIdxT idRs, idRt, exRs, exRt, exDest, memDest, wbDest;
    logic   idUsesRt, idBranch;
    logic   exRegWrite, exMemRead;
    logic   memRegWrite, memLoad, memBusy;
    logic   wbRegWrite;
    logic   fetchBusy;
    fwdSelT idRsFwd, idRtFwd, exRsFwd, exRtFwd;
    logic   stallFetch, stallDecode, stallAll;

    modport fetch (output fetchBusy, input stallFetch);
    modport decode (output idRs, idRt, idUsesRt, idBranch,
                    input idRsFwd, idRtFwd, stallDecode, stallAll);
    modport execute (output exRs, exRt, exDest, exRegWrite, exMemRead,
                     input exRsFwd, exRtFwd, stallAll);
    modport memory (output memDest, memRegWrite, memLoad, memBusy, wbDest, wbRegWrite,
                    input stallAll);
    modport hazard (input idRs, idRt, idUsesRt, idBranch, exRs, exRt, exDest, exRegWrite,
                    exMemRead, memDest, memRegWrite, memLoad, memBusy, wbDest, wbRegWrite,
                    fetchBusy,
                    output idRsFwd, idRtFwd, exRsFwd, exRtFwd, stallFetch, stallDecode,
                    stallAll);
endinterface

// ==== verilog/hazardUnit.sv ====
`timescale 1ns/1ns
module hazardUnit (
    hazardIf.hazard h
);
    import corePkg::*;
    import isaPkg::*;

    logic loadUse, branchHaz;
    logic exHitsRs, exHitsRt, memLoadHit;

    // Memory holds the younger result, so it wins over writeback
    function automatic fwdSelT fwdFor(regIdxT src);
        if (src == regZero)
            return fwdNone;
        if (h.memRegWrite && h.memDest == src)
            return fwdMem;
        if (h.wbRegWrite && h.wbDest == src)
            return fwdWb;
        return fwdNone;
    endfunction

    always_comb begin
        h.idRsFwd = fwdFor(h.idRs);
        h.idRtFwd = fwdFor(h.idRt);
        h.exRsFwd = fwdFor(h.exRs);
        h.exRtFwd = fwdFor(h.exRt);
    end

    assign exHitsRs = h.exRegWrite && h.exDest != regZero && h.exDest == h.idRs;
    assign exHitsRt = h.exRegWrite && h.exDest != regZero && h.exDest == h.idRt && h.idUsesRt;
    assign memLoadHit = h.memLoad && h.memDest != regZero
                        && (h.memDest == h.idRs || h.memDest == h.idRt);

    assign loadUse = h.exMemRead && (exHitsRs || exHitsRt);
    // Branch compares in decode, before execute or a load result can reach it
    assign branchHaz = h.idBranch && (exHitsRs || exHitsRt || memLoadHit);

    assign h.stallDecode = loadUse | branchHaz;
    assign h.stallAll    = h.fetchBusy | h.memBusy;
    assign h.stallFetch  = h.stallDecode | h.stallAll;

endmodule

// ==== verilog/isaPkg.sv ====
package isaPkg;

    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;
    typedef logic [4:0]  regIdxT;
    typedef logic [31:0] instrT;

    // Primary opcodes
    localparam opcodeT opSpecial = 6'h00;
    localparam opcodeT opAddiu   = 6'h09;
    localparam opcodeT opOri     = 6'h0d;
    localparam opcodeT opLui     = 6'h0f;
    localparam opcodeT opLw      = 6'h23;
    localparam opcodeT opSw      = 6'h2b;
    localparam opcodeT opBeq     = 6'h04;
    localparam opcodeT opBne     = 6'h05;

    // Function codes under opSpecial
    localparam functT fnAddu = 6'h21;
    localparam functT fnSubu = 6'h23;
    localparam functT fnAnd  = 6'h24;
    localparam functT fnOr   = 6'h25;
    localparam functT fnSlt  = 6'h2a;

    localparam int opLsb = 26;  // Low bit of each field
    localparam int rsLsb = 21;
    localparam int rtLsb = 16;
    localparam int rdLsb = 11;

    localparam regIdxT regZero  = 5'd0;
    localparam instrT  nopInstr = 32'h0000_0000;  // sll r0,r0,0

endpackage

// ==== verilog/memoryStage.sv ====
`timescale 1ns/1ns
module memoryStage (
    input  logic              clock,
    input  logic              rst,
    input  corePkg::wordT     memAluResult,
    input  corePkg::wordT     memStoreData,
    input  logic              memRead,
    input  logic              memWrite,
    input  logic              memRegWrite,
    input  isaPkg::regIdxT    memDest,
    input  corePkg::wordT     dataRdata,
    input  logic              dataAck,
    output logic              dataRead,
    output logic              dataWrite,
    output corePkg::wordAddrT dataAddr,
    output corePkg::wordT     dataWdata,
    output corePkg::wordT     memResult,
    output logic              wbRegWrite,
    output isaPkg::regIdxT    wbDest,
    output corePkg::wordT     wbData,
    hazardIf.memory           hazard
);
    import corePkg::*;

    memStateT state;
    wordT     loadData;  // Read word kept while fetch still holds the pipeline
    wordT     readVal;
    logic     idle;

    assign idle      = (state == memIdle);
    assign dataRead  = memRead & idle;
    assign dataWrite = memWrite & idle;
    assign dataAddr  = memAluResult[31:2];
    assign dataWdata = memStoreData;
    assign memResult = memAluResult;
    assign readVal   = idle ? dataRdata : loadData;

    assign hazard.memBusy     = (dataRead | dataWrite) & ~dataAck;
    assign hazard.memDest     = memDest;
    assign hazard.memRegWrite = memRegWrite;
    assign hazard.memLoad     = memRead;
    assign hazard.wbDest      = wbDest;
    assign hazard.wbRegWrite  = wbRegWrite;

    always_ff @(posedge clock) begin
        if (rst)
            state <= memIdle;
        else if (idle && (memRead || memWrite) && dataAck && hazard.stallAll)
            state <= memWait;
        else if (!hazard.stallAll)
            state <= memIdle;
    end

    always_ff @(posedge clock) begin
        if (idle && dataAck)
            loadData <= dataRdata;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wbRegWrite <= 1'b0;
        end else if (!hazard.stallAll) begin
            wbRegWrite <= memRegWrite;
            wbDest     <= memDest;
            wbData     <= memRead ? readVal : memAluResult;
        end
    end

endmodule

// ==== verilog/mipsCore.sv ====
`timescale 1ns/1ns
module mipsCore (
    input  logic              clock,
    input  logic              rst,
    input  isaPkg::instrT     instRdata,
    input  logic              instAck,
    output logic              instRead,
    output corePkg::wordAddrT instAddr,
    input  corePkg::wordT     dataRdata,
    input  logic              dataAck,
    output logic              dataRead,
    output logic              dataWrite,
    output corePkg::wordAddrT dataAddr,
    output corePkg::wordT     dataWdata
);
    import corePkg::*;
    import isaPkg::*;

    instrT  idInstr;
    wordT   idPcPlus4, branchTarget, rfRs, rfRt;
    logic   branchTaken;
    regIdxT rsIdx, rtIdx;

    // Decode to execute
    aluOpT  exAluOp;
    wordT   exA, exB, exStoreData, exImm;
    logic   exUseImm, exMemRead, exMemWrite, exRegWrite;
    regIdxT exDest, exRs, exRt;

    // Execute to memory, and the forwarding sources
    wordT   memAluResult, memStoreData, memResult, wbData;
    logic   memRead, memWrite, memRegWrite, wbRegWrite;
    regIdxT memDest, wbDest;

    hazardIf hz ();

    fetchUnit fetch_i (
        .clock, .rst, .instRdata, .instAck, .branchTaken, .branchTarget,
        .instRead, .instAddr, .idInstr, .idPcPlus4,
        .hazard (hz.fetch)
    );

    decodeStage decode_i (
        .clock, .rst, .idInstr, .idPcPlus4, .rfRs, .rfRt, .memResult, .wbData,
        .rsIdx, .rtIdx, .branchTaken, .branchTarget,
        .exAluOp, .exA, .exB, .exStoreData, .exUseImm, .exImm,
        .exMemRead, .exMemWrite, .exRegWrite, .exDest, .exRs, .exRt,
        .hazard (hz.decode)
    );

    registerFile regs_i (
        .clock, .rst, .rsIdx, .rtIdx, .rfRs, .rfRt, .wbRegWrite, .wbDest, .wbData
    );

    executeStage execute_i (
        .clock, .rst,
        .exAluOp, .exA, .exB, .exStoreData, .exUseImm, .exImm,
        .exMemRead, .exMemWrite, .exRegWrite, .exDest, .exRs, .exRt,
        .memResult, .wbData,
        .memAluResult, .memStoreData, .memRead, .memWrite, .memRegWrite, .memDest,
        .hazard (hz.execute)
    );

    memoryStage memory_i (
        .clock, .rst, .memAluResult, .memStoreData, .memRead, .memWrite,
        .memRegWrite, .memDest, .dataRdata, .dataAck,
        .dataRead, .dataWrite, .dataAddr, .dataWdata,
        .memResult, .wbRegWrite, .wbDest, .wbData,
        .hazard (hz.memory)
    );

    hazardUnit hazard_i (
        .h (hz.hazard)
    );

endmodule

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ns
module registerFile (
    input  logic           clock,
    input  logic           rst,
    input  isaPkg::regIdxT rsIdx,
    input  isaPkg::regIdxT rtIdx,
    output corePkg::wordT  rfRs,
    output corePkg::wordT  rfRt,
    input  logic           wbRegWrite,
    input  isaPkg::regIdxT wbDest,
    input  corePkg::wordT  wbData
);
    import corePkg::*;
    import isaPkg::*;

    wordT regs [32];
    logic writeEn;

    assign writeEn = wbRegWrite & (wbDest != regZero) & ~rst;

    always_ff @(posedge clock) begin
        if (writeEn)
            regs[wbDest] <= wbData;
    end

    // Same-cycle write shows through to the read
    assign rfRs = (rsIdx == regZero) ? '0 : (writeEn && wbDest == rsIdx) ? wbData : regs[rsIdx];
    assign rfRt = (rtIdx == regZero) ? '0 : (writeEn && wbDest == rtIdx) ? wbData : regs[rtIdx];

endmodule
